/* all.f */
+incdir+common
common/isaPkg.sv
common/ctrlPkg.sv
decode/controlUnit.sv
decode/registerFile.sv
decode/operandForm.sv
decode/decodeStage.sv
sim/decode_chk.sv
sim/decodeTb.sv

/* common/ctrlPkg.sv */
package ctrlPkg;

    // what goes back into the register file
    typedef enum logic [2:0] {
        REG_SRC_ALU  = 3'd0,
        REG_SRC_MEM  = 3'd1,
        REG_SRC_PC2  = 3'd2,
        REG_SRC_IMM  = 3'd3,
        REG_SRC_BTR  = 3'd4,
        REG_SRC_FLAG = 3'd5
    } regSrc_e;

    typedef enum logic [2:0] {
        ALU_SRC_REG    = 3'd0,
        ALU_SRC_IMM5   = 3'd1,
        ALU_SRC_IMM8   = 3'd2,
        ALU_SRC_IMM11  = 3'd3,
        ALU_SRC_ZERO   = 3'd4,
        ALU_SRC_RS_SHL = 3'd5
    } aluSrc_e;

    typedef enum logic [2:0] {
        ALU_OP_ADD = 3'd0,
        ALU_OP_AND = 3'd1,
        ALU_OP_OR  = 3'd2,
        ALU_OP_XOR = 3'd3,
        ALU_OP_ROL = 3'd4,
        ALU_OP_SLL = 3'd5,
        ALU_OP_ROR = 3'd6,
        ALU_OP_SRL = 3'd7
    } aluOp_e;

    typedef enum logic [1:0] {
        DST_RD_R  = 2'd0,
        DST_RD_I1 = 2'd1,
        DST_RS    = 2'd2,
        DST_R7    = 2'd3
    } dstSel_e;

    typedef struct packed {
        regSrc_e regDataSrc;
        aluSrc_e aluSrc1;
        aluSrc_e aluSrc2;
        aluOp_e  aluOp;
        logic    memEn;
        logic    memWr;
        logic    branch;
        logic    jump;
        logic    exception;
        logic    cin;
        logic    invA;
        logic    invB;
        logic    isSigned;
    } ctrlWord_t;

endpackage

/* common/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// width of a register and of an instruction
`define DATA_WIDTH 16

// architectural registers
`define NUM_REGS 8

// register index width
`define REG_IDX_W 3

`endif

/* common/isaPkg.sv */
`include "decode_params.svh"

package isaPkg;

    // 10100 to 10111 have no entry and decode as illegal
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_SIIC  = 5'b00010,
        OP_RTI   = 5'b00011,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_STU   = 5'b10011,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_SHIFT = 5'b11010,
        OP_ALU   = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // alu group meaning first, shift group meaning second
    typedef enum logic [1:0] {
        F_ADD_ROL  = 2'b00,
        F_SUB_SLL  = 2'b01,
        F_XOR_ROR  = 2'b10,
        F_ANDN_SRL = 2'b11
    } funct_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        funct_e                funct;
    } rFormat_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            imm5;
    } i1Format_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [7:0]            imm8;
    } i2Format_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [10:0] disp11;
    } jFormat_t;

    typedef union packed {
        rFormat_t  r;
        i1Format_t i1;
        i2Format_t i2;
        jFormat_t  j;
    } instrWord_u;

endpackage

/* decode/controlUnit.sv */
`include "decode_params.svh"

module controlUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  instrWord_u            instr,
    output ctrlWord_t             ctrl,
    output logic                  halt,
    output logic                  regWriteOut,
    output logic                  signedExt,
    output logic [`REG_IDX_W-1:0] writeReg
);

    dstSel_e dstSel;

    always_comb begin
        ctrl            = '0;
        ctrl.regDataSrc = REG_SRC_ALU;
        ctrl.aluSrc1    = ALU_SRC_REG;
        ctrl.aluSrc2    = ALU_SRC_REG;
        ctrl.aluOp      = ALU_OP_ADD;
        halt            = 1'b0;
        regWriteOut     = 1'b0;
        signedExt       = 1'b1;
        dstSel          = DST_RD_R;

        case (instr.r.opcode)
            OP_HALT: halt = 1'b1;
            OP_NOP: ;
            OP_SIIC: ctrl.exception = 1'b1;
            OP_RTI: ctrl.jump = 1'b1;
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                ctrl.aluSrc2 = ALU_SRC_IMM5;
                regWriteOut  = 1'b1;
                dstSel       = DST_RD_I1;
                // subi is imm - rs
                if (instr.r.opcode == OP_SUBI) begin
                    ctrl.invA = 1'b1;
                    ctrl.cin  = 1'b1;
                end
                if (instr.r.opcode == OP_XORI) begin
                    ctrl.aluOp = ALU_OP_XOR;
                    signedExt  = 1'b0;
                end
                if (instr.r.opcode == OP_ANDNI) begin
                    ctrl.aluOp = ALU_OP_AND;
                    ctrl.invB  = 1'b1;
                    signedExt  = 1'b0;
                end
            end
            OP_ST, OP_LD, OP_STU: begin
                // address is rs + imm5
                ctrl.aluSrc2 = ALU_SRC_IMM5;
                ctrl.memEn   = 1'b1;
                ctrl.memWr   = (instr.r.opcode != OP_LD);
                if (instr.r.opcode == OP_LD) begin
                    ctrl.regDataSrc = REG_SRC_MEM;
                    regWriteOut     = 1'b1;
                    dstSel          = DST_RD_I1;
                end
                if (instr.r.opcode == OP_STU) begin
                    regWriteOut = 1'b1;
                    dstSel      = DST_RS;
                end
            end
            OP_BTR: begin
                ctrl.regDataSrc = REG_SRC_BTR;
                regWriteOut     = 1'b1;
            end
            OP_ALU: begin
                regWriteOut = 1'b1;
                case (instr.r.funct)
                    F_ADD_ROL: ctrl.aluOp = ALU_OP_ADD;
                    F_SUB_SLL: begin
                        ctrl.invA = 1'b1;
                        ctrl.cin  = 1'b1;
                    end
                    F_XOR_ROR: ctrl.aluOp = ALU_OP_XOR;
                    default: begin
                        ctrl.aluOp = ALU_OP_AND;
                        ctrl.invB  = 1'b1;
                    end
                endcase
            end
            OP_SHIFT: begin
                regWriteOut = 1'b1;
                case (instr.r.funct)
                    F_ADD_ROL: ctrl.aluOp = ALU_OP_ROL;
                    F_SUB_SLL: ctrl.aluOp = ALU_OP_SLL;
                    F_XOR_ROR: ctrl.aluOp = ALU_OP_ROR;
                    default:   ctrl.aluOp = ALU_OP_SRL;
                endcase
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.regDataSrc = REG_SRC_FLAG;
                regWriteOut     = 1'b1;
                // rs - rt for the compares, sco keeps a plain add
                ctrl.invB       = (instr.r.opcode != OP_SCO);
                ctrl.cin        = (instr.r.opcode != OP_SCO);
                ctrl.isSigned   = (instr.r.opcode == OP_SLT) || (instr.r.opcode == OP_SLE);
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.aluSrc2  = ALU_SRC_ZERO;
                ctrl.branch   = 1'b1;
                ctrl.isSigned = (instr.r.opcode == OP_BLTZ) || (instr.r.opcode == OP_BGEZ);
            end
            OP_LBI: begin
                ctrl.regDataSrc = REG_SRC_IMM;
                regWriteOut     = 1'b1;
                dstSel          = DST_RS;
            end
            OP_SLBI: begin
                ctrl.aluSrc1 = ALU_SRC_RS_SHL;
                ctrl.aluSrc2 = ALU_SRC_IMM8;
                ctrl.aluOp   = ALU_OP_OR;
                regWriteOut  = 1'b1;
                dstSel       = DST_RS;
            end
            OP_J, OP_JAL: begin
                ctrl.aluSrc2 = ALU_SRC_IMM11;
                ctrl.jump    = 1'b1;
                if (instr.r.opcode == OP_JAL) begin
                    ctrl.regDataSrc = REG_SRC_PC2;
                    regWriteOut     = 1'b1;
                    dstSel          = DST_R7;
                end
            end
            OP_JR, OP_JALR: begin
                // target is rs + imm8
                ctrl.aluSrc2 = ALU_SRC_IMM8;
                ctrl.jump    = 1'b1;
                if (instr.r.opcode == OP_JALR) begin
                    ctrl.regDataSrc = REG_SRC_PC2;
                    regWriteOut     = 1'b1;
                    dstSel          = DST_R7;
                end
            end
            default: begin
                ctrl.exception = 1'b1;
                ctrl.memEn     = 1'b0;
                regWriteOut    = 1'b0;
            end
        endcase
    end

    always_comb begin
        writeReg = instr.r.rd;
        case (dstSel)
            DST_RD_R:  writeReg = instr.r.rd;
            DST_RD_I1: writeReg = instr.i1.rd;
            DST_RS:    writeReg = instr.r.rs;
            DST_R7:    writeReg = `REG_IDX_W'(`NUM_REGS - 1);
        endcase
    end

endmodule

/* decode/decodeStage.sv */
`include "decode_params.svh"

module decodeStage
    import isaPkg::*, ctrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  instrWord_u             instr,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   regWriteIn,
    output ctrlWord_t              ctrl,
    output logic                   halt,
    output logic                   regWriteOut,
    output logic [`DATA_WIDTH-1:0] read1Data,
    output logic [`DATA_WIDTH-1:0] read2Data,
    output logic [`DATA_WIDTH-1:0] immEight,
    output logic [`DATA_WIDTH-1:0] immEleven,
    output logic [`DATA_WIDTH-1:0] immFive,
    output logic [`DATA_WIDTH-1:0] btrOut
);

    logic                  signedExt;
    logic [`REG_IDX_W-1:0] writeReg;

    controlUnit control_i (
        .instr       (instr),
        .ctrl        (ctrl),
        .halt        (halt),
        .regWriteOut (regWriteOut),
        .signedExt   (signedExt),
        .writeReg    (writeReg)
    );

    // write enable comes back from write-back, not from this decode
    registerFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .read1Sel  (instr.r.rs),
        .read2Sel  (instr.r.rt),
        .writeReg  (writeReg),
        .writeData (writeData),
        .writeEn   (regWriteIn),
        .read1Data (read1Data),
        .read2Data (read2Data)
    );

    operandForm operand_i (
        .instr     (instr),
        .signedExt (signedExt),
        .read1Data (read1Data),
        .immEight  (immEight),
        .immEleven (immEleven),
        .immFive   (immFive),
        .btrOut    (btrOut)
    );

endmodule

/* decode/operandForm.sv */
`include "decode_params.svh"

module operandForm
    import isaPkg::*;
(
    input  instrWord_u             instr,
    input  logic                   signedExt,
    input  logic [`DATA_WIDTH-1:0] read1Data,
    output logic [`DATA_WIDTH-1:0] immEight,
    output logic [`DATA_WIDTH-1:0] immEleven,
    output logic [`DATA_WIDTH-1:0] immFive,
    output logic [`DATA_WIDTH-1:0] btrOut
);

    logic fillEight;
    logic fillEleven;
    logic fillFive;

    // fill bit is the field msb only in signed mode
    assign fillEight  = signedExt & instr.i2.imm8[7];
    assign fillEleven = signedExt & instr.j.disp11[10];
    assign fillFive   = signedExt & instr.i1.imm5[4];

    assign immEight  = {{(`DATA_WIDTH - 8){fillEight}}, instr.i2.imm8};
    assign immEleven = {{(`DATA_WIDTH - 11){fillEleven}}, instr.j.disp11};
    assign immFive   = {{(`DATA_WIDTH - 5){fillFive}}, instr.i1.imm5};

    // bit 0 of rs lands in bit 15
    always_comb begin
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            btrOut[i] = read1Data[`DATA_WIDTH - 1 - i];
        end
    end

endmodule

/* decode/registerFile.sv */
`include "decode_params.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_IDX_W-1:0]  read1Sel,
    input  logic [`REG_IDX_W-1:0]  read2Sel,
    input  logic [`REG_IDX_W-1:0]  writeReg,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   writeEn,
    output logic [`DATA_WIDTH-1:0] read1Data,
    output logic [`DATA_WIDTH-1:0] read2Data
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // no write-to-read bypass
    // same-cycle read of the written register sees the old value
    assign read1Data = regs[read1Sel];
    assign read2Data = regs[read2Sel];

endmodule

/* sim/decodeTb.sv */
`include "decode_params.svh"

module decodeTb
    import isaPkg::*, ctrlPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   rst;
    instrWord_u             instr;
    logic [`DATA_WIDTH-1:0] writeData;
    logic                   regWriteIn;
    ctrlWord_t              ctrl;
    logic                   halt;
    logic                   regWriteOut;
    logic [`DATA_WIDTH-1:0] read1Data;
    logic [`DATA_WIDTH-1:0] read2Data;
    logic [`DATA_WIDTH-1:0] immEight;
    logic [`DATA_WIDTH-1:0] immEleven;
    logic [`DATA_WIDTH-1:0] immFive;
    logic [`DATA_WIDTH-1:0] btrOut;
    logic [15:0]            lfsrState;
    int                     errorCount;
    int                     checkCount;

    decodeStage dut_i (.*);

    bind decodeStage decode_chk chk_i (
        .clk(clk), .rst(rst), .instr(instr), .writeData(writeData),
        .regWriteIn(regWriteIn), .writeReg(writeReg), .ctrl(ctrl), .halt(halt),
        .read1Data(read1Data), .read2Data(read2Data)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [15:0] encodeR(opcode_e op, logic [2:0] rs, logic [2:0] rt,
                                            logic [2:0] rd, funct_e f);
        return {op, rs, rt, rd, f};
    endfunction

    function automatic logic [15:0] encodeI1(opcode_e op, logic [2:0] rs, logic [2:0] rd,
                                             logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic logic [15:0] encodeI2(opcode_e op, logic [2:0] rs, logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic logic [15:0] encodeJ(opcode_e op, logic [10:0] disp11);
        return {op, disp11};
    endfunction

    task automatic compare(string name, logic [15:0] expected, logic [15:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic waitEdges(int n);
        int count;
        count = 0;
        while (count < n) begin
            @(posedge clk);
            count++;
        end
    endtask

    task automatic drive(logic [15:0] word, logic [15:0] wData, logic wEn);
        @(posedge clk);
        #1;
        instr      = word;
        writeData  = wData;
        regWriteIn = wEn;
    endtask

    // outputs have settled by the falling edge
    task automatic sample();
        @(negedge clk);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rst        = 1'b1;
        regWriteIn = 1'b0;
        instr      = encodeJ(OP_NOP, 11'd0);
        waitEdges(8);
        #1;
        rst = 1'b0;
    endtask

    task automatic writeReg(logic [2:0] idx, logic [15:0] value);
        drive(encodeI1(OP_ADDI, 3'd0, idx, 5'd0), value, 1'b1);
    endtask

    task automatic expectReg(string name, logic [2:0] idx, logic [15:0] value);
        drive(encodeR(OP_ALU, idx, idx, 3'd0, F_ADD_ROL), '0, 1'b0);
        sample();
        compare(name, value, read1Data);
        compare(name, value, read2Data);
    endtask

    task automatic testRegisterRoundTrip();
        logic [15:0] values [`NUM_REGS];
        for (int i = 0; i < `NUM_REGS; i++) begin
            values[i] = randBits(16);
            writeReg(3'(i), values[i]);
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            expectReg("round trip", 3'(i), values[i]);
        end
        applyReset();
        for (int i = 0; i < `NUM_REGS; i++) begin
            expectReg("cleared by reset", 3'(i), 16'd0);
        end
    endtask

    task automatic testImmediates();
        logic [4:0]  imm5;
        logic [10:0] disp;
        imm5 = {1'b1, 4'(randBits(4))};
        // rd of 6 puts a one in imm8 bit 7
        drive(encodeI1(OP_ADDI, 3'd1, 3'd6, imm5), '0, 1'b0);
        sample();
        compare("addi imm5", {{11{imm5[4]}}, imm5}, immFive);
        compare("addi imm8", {8'hff, 3'b110, imm5}, immEight);
        imm5 = {1'b1, 4'(randBits(4))};
        drive(encodeI1(OP_XORI, 3'd1, 3'd6, imm5), '0, 1'b0);
        sample();
        compare("xori imm5", {11'd0, imm5}, immFive);
        compare("xori imm8", {8'h00, 3'b110, imm5}, immEight);
        disp = {1'b1, 10'(randBits(10))};
        drive(encodeJ(OP_J, disp), '0, 1'b0);
        sample();
        compare("j disp11", {{5{disp[10]}}, disp}, immEleven);
    endtask

    // fields: aluOp, invA, invB, cin, memEn, memWr, branch, regWriteOut
    task automatic ctrlCase(string name, logic [15:0] word, logic [9:0] expected);
        drive(word, '0, 1'b0);
        sample();
        compare(name, 16'(expected), 16'({ctrl.aluOp, ctrl.invA, ctrl.invB, ctrl.cin,
            ctrl.memEn, ctrl.memWr, ctrl.branch, regWriteOut}));
    endtask

    task automatic testControlWords();
        ctrlCase("add", encodeR(OP_ALU, 3'd1, 3'd2, 3'd3, F_ADD_ROL), {ALU_OP_ADD, 7'b0000001});
        ctrlCase("sub", encodeR(OP_ALU, 3'd1, 3'd2, 3'd3, F_SUB_SLL), {ALU_OP_ADD, 7'b1010001});
        ctrlCase("xor", encodeR(OP_ALU, 3'd1, 3'd2, 3'd3, F_XOR_ROR), {ALU_OP_XOR, 7'b0000001});
        ctrlCase("andn", encodeR(OP_ALU, 3'd1, 3'd2, 3'd3, F_ANDN_SRL), {ALU_OP_AND, 7'b0100001});
        ctrlCase("ld", encodeI1(OP_LD, 3'd1, 3'd2, 5'd4), {ALU_OP_ADD, 7'b0001001});
        ctrlCase("st", encodeI1(OP_ST, 3'd1, 3'd2, 5'd4), {ALU_OP_ADD, 7'b0001100});
        ctrlCase("beqz", encodeI2(OP_BEQZ, 3'd1, 8'h10), {ALU_OP_ADD, 7'b0000010});
    endtask

    task automatic testDestinations();
        logic [15:0] rdValue;
        logic [15:0] lbiValue;
        logic [15:0] jalValue;
        rdValue  = randBits(16);
        lbiValue = randBits(16);
        jalValue = randBits(16);
        drive(encodeR(OP_ALU, 3'd1, 3'd2, 3'd5, F_ADD_ROL), rdValue, 1'b1);
        drive(encodeI2(OP_LBI, 3'd3, 8'h5a), lbiValue, 1'b1);
        drive(encodeJ(OP_JAL, 11'h123), jalValue, 1'b1);
        expectReg("r-format rd", 3'd5, rdValue);
        expectReg("lbi rs", 3'd3, lbiValue);
        expectReg("jal r7", 3'd7, jalValue);
    endtask

    task automatic testHaltIllegalReverse();
        logic [15:0] value;
        logic [15:0] reversed;
        drive(encodeJ(OP_HALT, 11'd0), '0, 1'b0);
        sample();
        compare("halt flag", 16'd1, 16'(halt));
        compare("halt exception", 16'd0, 16'(ctrl.exception));
        drive({5'b10100, 11'h2a5}, '0, 1'b0);
        sample();
        compare("illegal exception", 16'd1, 16'(ctrl.exception));
        compare("illegal regWriteOut", 16'd0, 16'(regWriteOut));
        value = randBits(16);
        reversed = {<<{value}};
        writeReg(3'd4, value);
        drive(encodeR(OP_BTR, 3'd4, 3'd0, 3'd6, F_ADD_ROL), '0, 1'b0);
        sample();
        compare("btr", reversed, btrOut);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        instr      = encodeJ(OP_NOP, 11'd0);
        writeData  = '0;
        regWriteIn = 1'b0;
        lfsrState  = 16'd33;
        errorCount = 0;
        checkCount = 0;
        applyReset();
        testRegisterRoundTrip();
        testImmediates();
        testControlWords();
        testDestinations();
        testHaltIllegalReverse();
        waitEdges(2);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim/decode_chk.sv */
`include "decode_params.svh"

module decode_chk
    import isaPkg::*, ctrlPkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input instrWord_u             instr,
    input logic [`DATA_WIDTH-1:0] writeData,
    input logic                   regWriteIn,
    input logic [`REG_IDX_W-1:0]  writeReg,
    input ctrlWord_t              ctrl,
    input logic                   halt,
    input logic [`DATA_WIDTH-1:0] read1Data,
    input logic [`DATA_WIDTH-1:0] read2Data
);
    timeunit 1ns;
    timeprecision 100ps;

    noHaltOnException: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.exception && halt))
        else $error("exception and halt high in the same cycle");

    storeNeedsMemEn: assert property (@(posedge clk) disable iff (rst)
        ctrl.memWr |-> ctrl.memEn)
        else $error("memWr high without memEn");

    // a write shows up on the read ports one cycle later
    readOneAfterWrite: assert property (@(posedge clk) disable iff (rst)
        ($past(regWriteIn) && !$past(rst) && instr.r.rs == $past(writeReg))
        |-> read1Data == $past(writeData))
        else $error("read port 1 does not show the last written value");

    readTwoAfterWrite: assert property (@(posedge clk) disable iff (rst)
        ($past(regWriteIn) && !$past(rst) && instr.r.rt == $past(writeReg))
        |-> read2Data == $past(writeData))
        else $error("read port 2 does not show the last written value");

endmodule
